// ==== logic/spn_defines.svh ====
`ifndef SPN_DEFINES_SVH
`define SPN_DEFINES_SVH

// bits per s-box lane.
`define SPN_LANE_W 6
// lanes per block.
`define SPN_LANES 4
// block and key width.
`define SPN_BLOCK_W 24
// rounds per encryption, 1 to 15.
`define SPN_ROUNDS 8
// round counter width.
`define SPN_RND_W 4
// bit i of the block moves to bit (stride * i) mod block width.
`define SPN_PERM_STRIDE 7

`endif

// ==== logic/spn_pkg.sv ====
`include "spn_defines.svh"

package spn_pkg;

  // one s-box word, also a tower-field element of three gf(4) digits.
  typedef logic [`SPN_LANE_W-1:0] lane_t;

  // block state, read flat by the permutation and per lane by the s-boxes.
  // lane 0 is the low six bits.
  typedef union packed {
    logic [`SPN_BLOCK_W-1:0] bits;
    lane_t [`SPN_LANES-1:0]  lanes;
  } block_t;

  typedef logic [`SPN_BLOCK_W-1:0] key_t;

  typedef logic [`SPN_RND_W-1:0] rnd_t;

endpackage

// ==== logic/gf4_tower_power.sv ====
`timescale 1ns/1ps

module gf4_tower_power (
  input  spn_pkg::lane_t a,
  output spn_pkg::lane_t b
);

  // per output digit, the constant applied to each of the 15 terms.
  localparam logic [1:0] COEF [3][15] = '{
    '{2'd1, 2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd3, 2'd1,
      2'd2, 2'd1, 2'd0, 2'd0, 2'd0, 2'd0, 2'd2},
    '{2'd0, 2'd2, 2'd3, 2'd0, 2'd3, 2'd0, 2'd0, 2'd2,
      2'd1, 2'd3, 2'd1, 2'd1, 2'd3, 2'd1, 2'd2},
    '{2'd0, 2'd3, 2'd3, 2'd3, 2'd0, 2'd1, 2'd2, 2'd0,
      2'd1, 2'd2, 2'd2, 2'd3, 2'd3, 2'd2, 2'd2}
  };

  logic [1:0] d [3];
  logic [1:0] sq [3];
  logic [1:0] term [15];
  logic [1:0] digit_out [3];

  function automatic logic [1:0] gf4_sq(input logic [1:0] x);
    return {x[1], x[0] ^ x[1]};
  endfunction

  function automatic logic [1:0] gf4_mul(input logic [1:0] x, input logic [1:0] y);
    logic t;
    t = x[1] & y[1];
    return {(x[0] & y[1]) ^ (x[1] & y[0]) ^ t, (x[0] & y[0]) ^ t};
  endfunction

  // x cubed is 1 for any nonzero x, so this just selects y.
  function automatic logic [1:0] gf4_cube_sel(input logic [1:0] x, input logic [1:0] y);
    logic t;
    t = x[0] | x[1];
    return {t & y[1], t & y[0]};
  endfunction

  function automatic logic [1:0] gf4_cmul(input logic [1:0] x, input logic [1:0] c);
    logic [1:0] r;
    case (c)
      2'd0:    r = 2'b00;
      2'd1:    r = x;
      2'd2:    r = {x[0] ^ x[1], x[1]};
      default: r = {x[0], x[0] ^ x[1]};
    endcase
    return r;
  endfunction

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      d[k]  = a[2*k +: 2];
      sq[k] = gf4_sq(d[k]);
    end

    term[0] = sq[0];
    term[1] = sq[1];
    term[2] = sq[2];
    term[3] = gf4_cube_sel(d[1], sq[0]);
    term[4] = gf4_cube_sel(d[2], sq[0]);
    term[5] = gf4_cube_sel(d[0], sq[1]);
    term[6] = gf4_cube_sel(d[2], sq[1]);
    term[7] = gf4_cube_sel(d[0], sq[2]);
    term[8] = gf4_cube_sel(d[1], sq[2]);
    term[9] = gf4_mul(d[0], d[1]);
    term[10] = gf4_mul(d[0], d[2]);
    term[11] = gf4_mul(d[1], d[2]);
    // three-digit products, each digit against the other two squared.
    term[12] = gf4_mul(d[0], gf4_mul(sq[1], sq[2]));
    term[13] = gf4_mul(d[1], gf4_mul(sq[0], sq[2]));
    term[14] = gf4_mul(d[2], gf4_mul(sq[0], sq[1]));

    for (int k = 0; k < 3; k++) begin
      digit_out[k] = 2'b00;
      for (int j = 0; j < 15; j++) begin
        digit_out[k] = digit_out[k] ^ gf4_cmul(term[j], COEF[k][j]);
      end
    end
  end

  assign b = {digit_out[2], digit_out[1], digit_out[0]};

endmodule

// ==== logic/sms_sbox.sv ====
`timescale 1ns/1ps

`include "spn_defines.svh"

module sms_sbox (
  input  spn_pkg::lane_t x,
  output spn_pkg::lane_t y
);

  spn_pkg::lane_t z;
  spn_pkg::lane_t w;
  spn_pkg::lane_t p;
  logic           t;

  // polynomial basis into the tower field.
  assign z[0] = x[0] ^ x[2] ^ x[3] ^ x[4];
  assign z[1] = x[2] ^ x[3] ^ x[4];
  assign z[2] = x[2] ^ x[4] ^ x[5];
  assign z[3] = x[1] ^ x[2] ^ x[3] ^ x[4];
  assign z[4] = x[2] ^ x[3] ^ x[5];
  assign z[5] = x[2] ^ x[3];

  gf4_tower_power u_power (
    .a (z),
    .b (w)
  );

  // and back again.
  assign p[0] = w[0] ^ w[2] ^ w[4] ^ w[5];
  assign p[1] = w[0] ^ w[1] ^ w[2] ^ w[3] ^ w[4];
  assign p[2] = w[4] ^ w[5];
  assign p[3] = w[1];
  assign p[4] = w[3] ^ w[4];
  assign p[5] = w[2] ^ w[3] ^ w[4];

  // affine term taken from the input word.
  assign t = x[2] ^ x[4];
  assign y = p ^ {`SPN_LANE_W{t}};

endmodule

// ==== logic/round_datapath.sv ====
`timescale 1ns/1ps

`include "spn_defines.svh"

module round_datapath (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load,
  input  logic             step,
  input  logic             finish,
  input  spn_pkg::block_t  plaintext,
  input  spn_pkg::key_t    round_key,
  output spn_pkg::block_t  state
);

  spn_pkg::block_t                     mixed;
  spn_pkg::block_t                     subst;
  spn_pkg::block_t                     permuted;
  spn_pkg::lane_t [`SPN_LANES-1:0]     sbox_out;

  // key addition lane by lane.
  always_comb begin
    for (int g = 0; g < `SPN_LANES; g++) begin
      mixed.lanes[g] = state.lanes[g] ^ round_key[g*`SPN_LANE_W +: `SPN_LANE_W];
    end
  end

  for (genvar g = 0; g < `SPN_LANES; g++) begin : g_sbox
    sms_sbox u_sbox (
      .x (mixed.lanes[g]),
      .y (sbox_out[g])
    );
  end

  always_comb begin
    subst.lanes   = sbox_out;
    permuted.bits = '0;
    for (int i = 0; i < `SPN_BLOCK_W; i++) begin
      permuted.bits[(i * `SPN_PERM_STRIDE) % `SPN_BLOCK_W] = subst.bits[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= '0;
    end else if (load) begin
      state <= plaintext;
    end else if (step) begin
      state <= permuted;
    end else if (finish) begin
      // whitening with the last round key.
      state <= mixed;
    end
  end

endmodule

// ==== logic/key_schedule.sv ====
`timescale 1ns/1ps

`include "spn_defines.svh"

module key_schedule (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           load,
  input  logic           step,
  input  spn_pkg::key_t  key,
  input  spn_pkg::rnd_t  round_idx,
  output spn_pkg::key_t  round_key
);

  localparam int KEY_ROT = 7;

  spn_pkg::key_t  rotated;
  spn_pkg::key_t  next_key;
  spn_pkg::lane_t sbox_out;

  assign rotated = (round_key << KEY_ROT) | (round_key >> (`SPN_BLOCK_W - KEY_ROT));

  sms_sbox u_sbox (
    .x (rotated[`SPN_LANE_W-1:0]),
    .y (sbox_out)
  );

  // round index lands in the low bits of the top lane.
  assign next_key = {rotated[`SPN_BLOCK_W-1 -: `SPN_LANE_W] ^ spn_pkg::lane_t'(round_idx),
                     rotated[`SPN_BLOCK_W-`SPN_LANE_W-1:`SPN_LANE_W],
                     sbox_out};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      round_key <= '0;
    end else if (load) begin
      round_key <= key;
    end else if (step) begin
      round_key <= next_key;
    end
  end

endmodule

// ==== logic/cipher_ctrl.sv ====
`timescale 1ns/1ps

`include "spn_defines.svh"

module cipher_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  output logic           load,
  output logic           step,
  output logic           finish,
  output logic           busy,
  output logic           done,
  output spn_pkg::rnd_t  round_idx
);

  typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_FIN} state_t;

  state_t st;

  assign busy   = (st != ST_IDLE);
  assign load   = start && (st == ST_IDLE);
  assign step   = (st == ST_RUN);
  assign finish = (st == ST_FIN);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      st        <= ST_IDLE;
      round_idx <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (st)
        ST_IDLE: begin
          round_idx <= '0;
          if (start) st <= ST_RUN;
        end
        ST_RUN: begin
          if (round_idx == spn_pkg::rnd_t'(`SPN_ROUNDS - 1)) begin
            st <= ST_FIN;
          end else begin
            round_idx <= round_idx + 1'b1;
          end
        end
        default: begin
          st   <= ST_IDLE;
          done <= 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== logic/spn_cipher_top.sv ====
`timescale 1ns/1ps

module spn_cipher_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  spn_pkg::block_t  plaintext,
  input  spn_pkg::key_t    key,
  output spn_pkg::block_t  ciphertext,
  output logic             busy,
  output logic             done
);

  logic          load;
  logic          step;
  logic          finish;
  spn_pkg::rnd_t round_idx;
  spn_pkg::key_t round_key;

  cipher_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .load      (load),
    .step      (step),
    .finish    (finish),
    .busy      (busy),
    .done      (done),
    .round_idx (round_idx)
  );

  round_datapath u_datapath (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .step      (step),
    .finish    (finish),
    .plaintext (plaintext),
    .round_key (round_key),
    .state     (ciphertext)
  );

  key_schedule u_key_schedule (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (load),
    .step      (step),
    .key       (key),
    .round_idx (round_idx),
    .round_key (round_key)
  );

endmodule

// ==== tb/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== tb/tb_spn_cipher.sv ====
`timescale 1ns/1ps

`include "spn_defines.svh"

module tb_spn_cipher;

  localparam int CYCLE_NS = 20;
  localparam int RUNS     = 45;
  localparam int LIMIT_NS = (RUNS * (`SPN_ROUNDS + 10) + 16 + 4) * CYCLE_NS;
  // bit j of row r in the basis change matrices selects input bit j.
  localparam logic [5:0] FWD_ROWS [6] = '{6'h1d, 6'h1c, 6'h34, 6'h1e, 6'h2c, 6'h0c};
  localparam logic [5:0] INV_ROWS [6] = '{6'h35, 6'h1f, 6'h30, 6'h02, 6'h18, 6'h1c};

  logic            clk;
  logic            rst_n;
  logic            start;
  spn_pkg::block_t plaintext;
  spn_pkg::key_t   key;
  spn_pkg::block_t ciphertext;
  logic            busy;
  logic            done;

  int          errors;
  int          checks;
  logic [31:0] lfsr;

  tb_clkgen #(.PERIOD_NS(CYCLE_NS)) u_clkgen (.clk(clk));

  spn_cipher_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .plaintext  (plaintext),
    .key        (key),
    .ciphertext (ciphertext),
    .busy       (busy),
    .done       (done)
  );

  // shift-and-add gf(4) multiply with w^2 = w + 1.
  function automatic logic [1:0] gf4_mult(input logic [1:0] a, input logic [1:0] b);
    logic [2:0] p;
    p = 3'b000;
    if (b[0]) p = p ^ {1'b0, a};
    if (b[1]) p = p ^ {a, 1'b0};
    if (p[2]) p = p ^ 3'b111;
    return p[1:0];
  endfunction

  function automatic spn_pkg::lane_t tower_mult(input spn_pkg::lane_t a, input spn_pkg::lane_t b);
    logic [1:0] c [5];
    for (int d = 0; d < 5; d++) begin
      c[d] = 2'b00;
    end
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        c[i+j] = c[i+j] ^ gf4_mult(a[2*i +: 2], b[2*j +: 2]);
      end
    end
    // alpha^3 = w^2 + w alpha + w^2 alpha^2.
    for (int d = 4; d >= 3; d--) begin
      c[d-3] = c[d-3] ^ gf4_mult(c[d], 2'd3);
      c[d-2] = c[d-2] ^ gf4_mult(c[d], 2'd2);
      c[d-1] = c[d-1] ^ gf4_mult(c[d], 2'd3);
    end
    return {c[2], c[1], c[0]};
  endfunction

  function automatic spn_pkg::lane_t power_41(input spn_pkg::lane_t a);
    spn_pkg::lane_t r;
    r = 6'd1;
    for (int n = 0; n < 41; n++) begin
      r = tower_mult(r, a);
    end
    return r;
  endfunction

  function automatic spn_pkg::lane_t linear_map(input spn_pkg::lane_t v, input bit inverse);
    spn_pkg::lane_t r;
    for (int k = 0; k < 6; k++) begin
      r[k] = ^(v & (inverse ? INV_ROWS[k] : FWD_ROWS[k]));
    end
    return r;
  endfunction

  function automatic spn_pkg::lane_t sbox_model(input spn_pkg::lane_t x);
    spn_pkg::lane_t p;
    p = linear_map(power_41(linear_map(x, 1'b0)), 1'b1);
    return p ^ {`SPN_LANE_W{x[2] ^ x[4]}};
  endfunction

  function automatic spn_pkg::key_t next_round_key(input spn_pkg::key_t k, input int r);
    spn_pkg::key_t n;
    n = {k[`SPN_BLOCK_W-8:0], k[`SPN_BLOCK_W-1 -: 7]};
    n[`SPN_LANE_W-1:0] = sbox_model(n[`SPN_LANE_W-1:0]);
    n[`SPN_BLOCK_W-1 -: `SPN_LANE_W] = n[`SPN_BLOCK_W-1 -: `SPN_LANE_W] ^ 6'(r);
    return n;
  endfunction

  function automatic spn_pkg::block_t encrypt_model(input spn_pkg::block_t pt,
                                                    input spn_pkg::key_t k);
    logic [`SPN_BLOCK_W-1:0] st;
    logic [`SPN_BLOCK_W-1:0] s;
    spn_pkg::key_t           rk;
    spn_pkg::block_t         res;
    st = pt.bits;
    rk = k;
    for (int r = 0; r < `SPN_ROUNDS; r++) begin
      st = st ^ rk;
      for (int g = 0; g < `SPN_LANES; g++) begin
        s[g*`SPN_LANE_W +: `SPN_LANE_W] = sbox_model(st[g*`SPN_LANE_W +: `SPN_LANE_W]);
      end
      for (int i = 0; i < `SPN_BLOCK_W; i++) begin
        st[(i * `SPN_PERM_STRIDE) % `SPN_BLOCK_W] = s[i];
      end
      rk = next_round_key(rk, r);
    end
    res.bits = st ^ rk;
    return res;
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic random_word(output logic [`SPN_BLOCK_W-1:0] w);
    for (int b = 0; b < `SPN_BLOCK_W; b++) begin
      w[b] = lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_block(input spn_pkg::block_t got, input spn_pkg::block_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s got %h expected %h", $time, what, got.bits, exp.bits);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // every task starts and ends 2 ns after a rising edge.
  task automatic start_run(input spn_pkg::block_t pt, input spn_pkg::key_t k);
    plaintext = pt;
    key       = k;
    start     = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!done && n < `SPN_ROUNDS + 10) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!done) begin
      errors++;
      $display("done never came back after a start at %0t ns", $time);
    end
  endtask

  task automatic encrypt_and_check(input spn_pkg::block_t pt, input spn_pkg::key_t k,
                                   input string what);
    start_run(pt, k);
    wait_done();
    check_block(ciphertext, encrypt_model(pt, k), what);
  endtask

  task automatic reset_values();
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(done, 1'b0, "done after reset");
    check_block(ciphertext, '0, "ciphertext after reset");
  endtask

  task automatic known_vectors();
    encrypt_and_check('0, '0, "zero key and plaintext");
    encrypt_and_check('1, '1, "all-ones key and plaintext");
  endtask

  task automatic exact_latency();
    plaintext = 24'h123456;
    key       = 24'habcdef;
    start     = 1'b1;
    for (int n = 1; n <= `SPN_ROUNDS + 3; n++) begin
      @(posedge clk);
      #2;
      start = 1'b0;
      check_flag(done, n == `SPN_ROUNDS + 2, $sformatf("done after edge %0d", n));
      check_flag(busy, n <= `SPN_ROUNDS + 1, $sformatf("busy after edge %0d", n));
    end
    check_block(ciphertext, encrypt_model(24'h123456, 24'habcdef), "latency run result");
  endtask

  task automatic start_while_busy();
    start_run(24'h0f0f0f, 24'h5a5a5a);
    repeat (3) begin
      @(posedge clk);
      #2;
    end
    start_run(24'h777777, 24'h010203);
    wait_done();
    check_block(ciphertext, encrypt_model(24'h0f0f0f, 24'h5a5a5a), "result with ignored start");
    repeat (`SPN_ROUNDS + 4) begin
      @(posedge clk);
      #2;
      check_flag(done, 1'b0, "extra done after ignored start");
      check_flag(busy, 1'b0, "busy after ignored start");
    end
  endtask

  task automatic random_vectors();
    logic [`SPN_BLOCK_W-1:0] pt;
    logic [`SPN_BLOCK_W-1:0] k;
    for (int i = 0; i < 40; i++) begin
      random_word(pt);
      random_word(k);
      encrypt_and_check(pt, k, $sformatf("random vector %0d", i));
    end
  endtask

  task automatic hold_after_done();
    spn_pkg::block_t         held;
    logic [`SPN_BLOCK_W-1:0] w;
    held = encrypt_model(24'hc0ffee, 24'h31337a);
    encrypt_and_check(24'hc0ffee, 24'h31337a, "hold run result");
    repeat (10) begin
      random_word(w);
      plaintext = w;
      random_word(w);
      key = w;
      @(posedge clk);
      #2;
      check_block(ciphertext, held, "ciphertext hold after done");
    end
  endtask

  initial begin
    #(LIMIT_NS);
    $display("Timeout: the tests did not finish in %0d ns", LIMIT_NS);
    $display("Regression failed");
    $finish;
  end

  initial begin
    errors    = 0;
    checks    = 0;
    lfsr      = 32'hc5c;
    rst_n     = 1'b0;
    start     = 1'b0;
    plaintext = '0;
    key       = '0;
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    reset_values();
    known_vectors();
    exact_latency();
    start_while_busy();
    random_vectors();
    hold_after_done();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/spn_pkg.sv
logic/gf4_tower_power.sv
logic/sms_sbox.sv
logic/round_datapath.sv
logic/key_schedule.sv
logic/cipher_ctrl.sv
logic/spn_cipher_top.sv
tb/tb_clkgen.sv
tb/tb_spn_cipher.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_spn_cipher -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log

if grep -q "Regression passed" sim.log; then
  echo "simulation result: pass"
else
  echo "simulation result: fail"
  exit 1
fi
